/* src.f */
rtl/exec_pkg.sv
rtl/exec_sequencer.sv
rtl/register_file.sv
rtl/operand_mux.sv
rtl/alu.sv
rtl/mem_interface.sv
rtl/execution_unit.sv
testbench/tb_execution_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_execution_unit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_execution_unit.sv */
`timescale 1ns/1ps

module tb_execution_unit import exec_pkg::*; ();

  localparam int N_LOAD  = 16;                  // Immediate loads, one per register
  localparam int N_REG   = 40;                  // Random register-direct ops
  localparam int N_MEM   = 16;                  // Memory source, then memory destination
  localparam int N_BYTE  = 16;
  localparam int N_TESTS = N_LOAD + N_REG + N_MEM + N_BYTE;

  typedef struct packed {
    data_t  res;
    flags_t f;
  } alu_ref_t;

  logic      mclk, puc, inst_valid, inst_ready;
  dec_inst_t inst;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;
  reg_idx_t  dbg_reg_sel;
  data_t     dbg_reg_data;
  flags_t    flags;

  data_t     mem [256];                         // Word array, indexed by adr[8:1]
  data_t     ref_regs [16];                     // Expected register contents
  flags_t    ref_flags;
  data_t     exp_rd_q [$];                      // Read addresses still due
  wb_req_t   exp_wr;                            // Expected write beat
  logic      wr_pending;
  logic      busy;                              // Slave inside a transfer
  int        waits;
  data_t     rd_word;
  integer    seed;

  execution_unit UUT (.mclk, .puc, .inst, .inst_valid, .inst_ready, .wb_req, .wb_rsp,
                      .dbg_reg_sel, .dbg_reg_data, .flags);

  initial begin
    mclk = 1'b0;
    forever #2 mclk = ~mclk;                    // 4 ns period
  end

  //======================================================================
  // Reference model and compare tasks
  //======================================================================
  function automatic logic sign_of(input data_t x, input logic bw);
    return bw ? x[7] : x[15];
  endfunction

  function automatic alu_ref_t ref_alu(input alu_op_e op, input logic bw, input data_t src,
                                       input data_t dst, input flags_t old);
    alu_ref_t    r;
    data_t       s;
    data_t       d;
    logic [16:0] wide;
    s    = bw ? {8'h00, src[7:0]} : src;        // Operands at width
    d    = bw ? {8'h00, dst[7:0]} : dst;
    r.f  = old;
    case (op)
      ALU_ADD:          wide = {1'b0, d} + {1'b0, s};
      ALU_SUB, ALU_CMP: wide = {1'b0, d} - {1'b0, s};
      ALU_AND:          wide = {1'b0, d & s};
      ALU_BIS:          wide = {1'b0, d | s};
      ALU_XOR:          wide = {1'b0, d ^ s};
      default:          wide = {1'b0, s};       // MOV
    endcase
    r.res = bw ? {8'h00, wide[7:0]} : wide[15:0];
    if ((op != ALU_MOV) && (op != ALU_BIS)) begin
      r.f.n = sign_of(r.res, bw);
      r.f.z = (r.res == 16'h0000);
    end
    case (op)
      ALU_ADD: begin
        r.f.c = bw ? wide[8] : wide[16];
        r.f.v = (sign_of(d, bw) == sign_of(s, bw)) && (sign_of(r.res, bw) != sign_of(d, bw));
      end
      ALU_SUB, ALU_CMP: begin
        r.f.c = (d >= s);                       // Set when no borrow
        r.f.v = (sign_of(d, bw) != sign_of(s, bw)) && (sign_of(r.res, bw) != sign_of(d, bw));
      end
      ALU_AND, ALU_XOR: begin
        r.f.c = !r.f.z;
        r.f.v = (op == ALU_XOR) && sign_of(d, bw) && sign_of(s, bw);
      end
      default: ;                                // MOV and BIS keep flags
    endcase
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input data_t got, input data_t exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_flags(input flags_t got, input flags_t exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0d ns: flags vnzc are %b, expected %b", $time, got, exp));
  endtask

  task automatic check_bus(input wb_req_t got, input wb_req_t exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0d ns: write beat is %h, expected %h", $time, got, exp));
  endtask

  task automatic check_regs();
    for (int k = 0; k < 16; k++) begin
      dbg_reg_sel = 4'(k);
      #0.1;                                     // Let the debug read settle
      check_word($sformatf("R%0d", k), dbg_reg_data, ref_regs[4'(k)]);
    end
  endtask

  //======================================================================
  // Wishbone memory model
  //======================================================================
  task automatic finish_transfer();
    data_t a;
    a = wb_req.adr;
    if (wb_req.we) begin
      if (!wr_pending) abort_run("A write cycle appeared where the test expects none");
      check_bus(wb_req, exp_wr);
      if (wb_req.sel[1]) mem[a[8:1]][15:8] = wb_req.dat[15:8];
      if (wb_req.sel[0]) mem[a[8:1]][7:0]  = wb_req.dat[7:0];
      wr_pending = 1'b0;
    end else begin
      if (exp_rd_q.size() == 0) abort_run("A read cycle appeared where the test expects none");
      check_word("read address", a, exp_rd_q.pop_front());
    end
  endtask

  always @(posedge mclk) begin
    if (!puc && wb_req.cyc && wb_req.stb) begin
      if (wb_rsp.ack) begin                     // Beat ends on this edge
        finish_transfer();
        #1;
        wb_rsp = '0;
        busy   = 1'b0;
      end else begin
        if (!busy) begin
          busy  = 1'b1;
          waits = $random(seed) & 3;            // 0 to 3 wait states
        end
        if (waits == 0) begin
          rd_word = wb_req.we ? 16'h0000 : mem[wb_req.adr[8:1]];
          #1;
          wb_rsp.dat = rd_word;
          wb_rsp.ack = 1'b1;
        end else begin
          waits--;
        end
      end
    end
  end

  //======================================================================
  // Stimulus
  //======================================================================
  function automatic data_t rand_word();
    return 16'($random(seed));
  endfunction

  function automatic reg_idx_t rand_reg();
    return 4'($random(seed));
  endfunction

  function automatic alu_op_e rand_op();
    return alu_op_e'(3'($unsigned($random(seed)) % 7));
  endfunction

  function automatic data_t mem_operand(input data_t adr, input logic bw);
    data_t w;
    w = mem[adr[8:1]];
    if (!bw) return w;
    return adr[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};  // Odd byte sits in the high lane
  endfunction

  function automatic dec_inst_t build_inst(input alu_op_e op, input logic bw,
                                           input src_mode_e as, input dst_mode_e ad,
                                           input reg_idx_t src, input reg_idx_t dst,
                                           input data_t sext, input data_t dext);
    return '{op: op, bw: bw, as: as, ad: ad, src: src, dst: dst, sext: sext, dext: dext};
  endfunction

  task automatic run_inst(input dec_inst_t i);
    @(posedge mclk);
    #1;
    inst       = i;
    inst_valid = 1'b1;
    @(posedge mclk);
    while (!inst_ready) @(posedge mclk);        // Handshake edge
    #1;
    inst_valid = 1'b0;
    @(posedge mclk);
    while (!inst_ready) @(posedge mclk);        // Back in IDLE
    #1;
  endtask

  task automatic execute_and_compare(input dec_inst_t i);
    data_t    s;
    data_t    d;
    data_t    a_dst;
    alu_ref_t r;
    a_dst = (i.ad == AD_IDX) ? ref_regs[i.dst] + i.dext : i.dext;
    case (i.as)
      AS_REG:  s = ref_regs[i.src];
      AS_IMM:  s = i.sext;
      default: begin
        exp_rd_q.push_back((i.as == AS_IDX) ? ref_regs[i.src] + i.sext : i.sext);
        s = mem_operand(exp_rd_q[0], i.bw);
      end
    endcase
    if (i.ad == AD_REG) begin
      d = ref_regs[i.dst];
    end else begin
      exp_rd_q.push_back(a_dst);                // Destination read follows source read
      d = mem_operand(a_dst, i.bw);
    end
    r         = ref_alu(i.op, i.bw, s, d, ref_flags);
    ref_flags = r.f;
    if (i.op != ALU_CMP) begin
      if (i.ad == AD_REG) begin
        ref_regs[i.dst] = r.res;
      end else begin
        exp_wr = '{cyc: 1'b1, stb: 1'b1, we: 1'b1,
                   sel: !i.bw ? 2'b11 : (a_dst[0] ? 2'b10 : 2'b01),
                   adr: a_dst, dat: i.bw ? {2{r.res[7:0]}} : r.res};
        wr_pending = 1'b1;
      end
    end
    run_inst(i);
    if (exp_rd_q.size() != 0) abort_run("An expected memory read never happened on the bus");
    if (wr_pending) abort_run("The result write cycle never happened on the bus");
    check_flags(flags, ref_flags);
    check_regs();
  endtask

  initial begin
    repeat (N_TESTS * 20 + 8) @(posedge mclk);  // Reset plus worst case per test
    abort_run("Timeout: the DUT stopped returning to IDLE");
  end

  initial begin
    dec_inst_t i;
    data_t     a;
    seed        = 32'hbab51d0d;
    puc         = 1'b1;
    inst        = '0;
    inst_valid  = 1'b0;
    wb_rsp      = '0;
    dbg_reg_sel = '0;
    exp_wr      = '0;
    wr_pending  = 1'b0;
    busy        = 1'b0;
    waits       = 0;
    ref_flags   = '0;
    for (int k = 0; k < 16; k++) ref_regs[4'(k)] = '0;
    for (int k = 0; k < 256; k++) mem[8'(k)] = {8'(k) ^ 8'h5a, ~8'(k)};
    repeat (8) @(posedge mclk);
    #1;
    puc = 1'b0;

    if (!inst_ready || wb_req.cyc || wb_req.stb || wb_req.we)
      abort_run("The DUT is not idle with a quiet bus after reset");
    check_flags(flags, '0);
    check_regs();

    for (int k = 0; k < N_LOAD; k++)            // MOV #x, Rk
      execute_and_compare(build_inst(ALU_MOV, 1'b0, AS_IMM, AD_REG, 4'h0, 4'(k),
                                     rand_word(), 16'h0000));
    for (int k = 0; k < N_REG; k++)
      execute_and_compare(build_inst(rand_op(), 1'b0, AS_REG, AD_REG, rand_reg(), rand_reg(),
                                     16'h0000, 16'h0000));
    for (int k = 0; k < N_MEM; k++) begin       // Every op in turn, CMP on a memory dst
      if (k < 8)
        i = build_inst(alu_op_e'(3'(k % 7)), 1'b0, k[0] ? AS_ABS : AS_IDX, AD_REG,
                       rand_reg(), rand_reg(), k[0] ? rand_word() & 16'h01fe : rand_word(),
                       16'h0000);
      else
        i = build_inst(alu_op_e'(3'(k % 7)), 1'b0, k[1] ? AS_IMM : AS_REG,
                       k[0] ? AD_ABS : AD_IDX, rand_reg(), rand_reg(), rand_word(),
                       rand_word() & 16'h01fe);
      execute_and_compare(i);
    end
    for (int k = 0; k < N_BYTE; k++) begin
      a = (rand_word() & 16'h01fe) | {15'h0000, k[2]};  // Even and odd in turn
      case (k % 4)
        0:       i = build_inst(rand_op(), 1'b1, AS_REG, AD_REG, rand_reg(), rand_reg(),
                                16'h0000, 16'h0000);
        1:       i = build_inst(rand_op(), 1'b1, AS_ABS, AD_REG, rand_reg(), rand_reg(),
                                a, 16'h0000);
        2:       i = build_inst(k[3] ? ALU_ADD : ALU_XOR, 1'b1, AS_REG, AD_ABS, rand_reg(),
                                rand_reg(), 16'h0000, a);
        default: i = build_inst(rand_op(), 1'b1, AS_IDX, AD_IDX, rand_reg(), rand_reg(),
                                rand_word(), rand_word());
      endcase
      execute_and_compare(i);
    end

    $display("Test OK");
    $finish;
  end

endmodule

/* rtl/execution_unit.sv */
`timescale 1ns/1ps

module execution_unit import exec_pkg::*; (
  input  logic      mclk,
  input  logic      puc,
  input  dec_inst_t inst,
  input  logic      inst_valid,
  output logic      inst_ready,
  output wb_req_t   wb_req,
  input  wb_rsp_t   wb_rsp,
  input  reg_idx_t  dbg_reg_sel,
  output data_t     dbg_reg_data,
  output flags_t    flags
);

  exec_state_e state;
  dec_inst_t   cur;
  mem_ctl_t    mem_ctl;
  data_t       reg_src, reg_dst;
  data_t       src_buf, dst_buf;
  data_t       op_src, op_dst;
  data_t       alu_out, alu_add;
  flags_t      alu_flags, alu_flags_wr;
  logic        exec;
  logic        reg_wr;

  assign exec   = (state == E_EXEC);
  assign reg_wr = exec && (cur.ad == AD_REG) && (cur.op != ALU_CMP);  // CMP keeps dst

  exec_sequencer u_seq (.mclk, .puc, .inst, .inst_valid, .inst_ready,
                        .ack(wb_rsp.ack), .state, .cur, .mem_ctl);

  register_file u_rf (.mclk, .puc, .src_sel(cur.src), .dst_sel(cur.dst), .dbg_reg_sel,
                      .wr_en(reg_wr), .wr_data(alu_out), .bw(cur.bw),
                      .flags_wr(alu_flags_wr), .flags_in(alu_flags),
                      .reg_src, .reg_dst, .dbg_reg_data, .flags);

  operand_mux u_opmux (.state, .cur, .reg_src, .reg_dst, .src_buf, .dst_buf, .op_src, .op_dst);

  alu u_alu (.op_src, .op_dst, .cur, .exec, .alu_out, .alu_add, .flags_in(flags),
             .flags_out(alu_flags), .flags_wr(alu_flags_wr));

  mem_interface u_mem (.mclk, .puc, .mem_ctl, .bw(cur.bw), .alu_add, .alu_out, .exec,
                       .wb_req, .wb_rsp, .src_buf, .dst_buf);

endmodule

/* rtl/mem_interface.sv */
`timescale 1ns/1ps

module mem_interface import exec_pkg::*; (
  input  logic     mclk,
  input  logic     puc,
  input  mem_ctl_t mem_ctl,
  input  logic     bw,
  input  data_t    alu_add,
  input  data_t    alu_out,
  input  logic     exec,
  output wb_req_t  wb_req,
  input  wb_rsp_t  wb_rsp,
  output data_t    src_buf,
  output data_t    dst_buf
);

  data_t     wdat_q;                            // Result held for DST_WR
  mem_word_u rd_raw;
  mem_word_u rd_fmt;
  logic      rd_ack;

  //======================================================================
  // Wishbone request
  //======================================================================
  assign wb_req.cyc = mem_ctl.req;
  assign wb_req.stb = mem_ctl.req;              // Single beat per phase
  assign wb_req.we  = mem_ctl.we;
  assign wb_req.adr = alu_add;
  assign wb_req.sel = !bw        ? 2'b11 :
                      alu_add[0] ? 2'b10 : 2'b01;  // Odd address is hi lane
  assign wb_req.dat = wdat_q;

  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      wdat_q <= '0;
    end else if (exec) begin
      wdat_q <= bw ? {2{alu_out[7:0]}} : alu_out;  // Byte on both lanes
    end
  end

  //======================================================================
  // Read data formatting and buffers
  //======================================================================
  assign rd_raw.word = wb_rsp.dat;

  always_comb begin
    rd_fmt = rd_raw;
    if (bw && alu_add[0]) begin
      rd_fmt.b.lo = rd_raw.b.hi;                // Odd byte down to lane 0
    end
  end

  assign rd_ack = mem_ctl.req && !mem_ctl.we && wb_rsp.ack;

  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      src_buf <= '0;
      dst_buf <= '0;
    end else if (rd_ack) begin
      if (mem_ctl.phase) dst_buf <= rd_fmt.word;
      else               src_buf <= rd_fmt.word;
    end
  end

  // Request fields hold through wait states
  a_req_stable: assert property (@(posedge mclk) disable iff (puc)
    (wb_req.stb && !wb_rsp.ack) |=>
      (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we) &&
       $stable(wb_req.sel) && $stable(wb_req.dat)));

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu import exec_pkg::*; (
  input  data_t     op_src,
  input  data_t     op_dst,
  input  dec_inst_t cur,
  input  logic      exec,
  output data_t     alu_out,
  output data_t     alu_add,
  input  flags_t    flags_in,
  output flags_t    flags_out,
  output flags_t    flags_wr
);

  logic        sub;
  data_t       add_b;
  logic [16:0] sum_w;
  logic [8:0]  sum_b;
  data_t       res_raw;
  data_t       res;
  logic        msb_src;
  logic        msb_dst;
  logic        msb_b;
  logic        msb_res;
  logic        arith;
  logic        logic_op;

  assign alu_add = op_src + op_dst;             // Address adder

  //======================================================================
  // Result path
  //======================================================================
  assign sub   = (cur.op == ALU_SUB) || (cur.op == ALU_CMP);
  assign add_b = sub ? ~op_src : op_src;        // dst + ~src + 1
  assign sum_w = {1'b0, op_dst} + {1'b0, add_b} + {16'h0000, sub};
  assign sum_b = {1'b0, op_dst[7:0]} + {1'b0, add_b[7:0]} + {8'h00, sub};

  always_comb begin
    case (cur.op)
      ALU_ADD, ALU_SUB, ALU_CMP: res_raw = sum_w[15:0];
      ALU_AND: res_raw = op_dst & op_src;
      ALU_BIS: res_raw = op_dst | op_src;
      ALU_XOR: res_raw = op_dst ^ op_src;
      default: res_raw = op_src;                // MOV
    endcase
  end

  assign res     = cur.bw ? {8'h00, res_raw[7:0]} : res_raw;
  assign alu_out = res;

  //======================================================================
  // Flags
  //======================================================================
  assign msb_src = cur.bw ? op_src[7] : op_src[15];
  assign msb_dst = cur.bw ? op_dst[7] : op_dst[15];
  assign msb_b   = cur.bw ? add_b[7]  : add_b[15];
  assign msb_res = cur.bw ? res[7]    : res[15];

  assign arith    = (cur.op == ALU_ADD) || sub;
  assign logic_op = (cur.op == ALU_AND) || (cur.op == ALU_XOR);

  always_comb begin
    flags_out   = flags_in;                     // MOV and BIS keep flags
    flags_out.n = msb_res;
    flags_out.z = (res == 16'h0000);            // High byte already cleared in .B
    if (arith) begin
      flags_out.c = cur.bw ? sum_b[8] : sum_w[16];
      flags_out.v = (msb_dst == msb_b) && (msb_res != msb_dst);
    end else if (logic_op) begin
      flags_out.c = (res != 16'h0000);
      flags_out.v = (cur.op == ALU_XOR) && msb_src && msb_dst;
    end
  end

  assign flags_wr = (exec && (arith || logic_op)) ? 4'b1111 : 4'b0000;

endmodule

/* rtl/operand_mux.sv */
`timescale 1ns/1ps

module operand_mux import exec_pkg::*; (
  input  exec_state_e state,
  input  dec_inst_t   cur,
  input  data_t       reg_src,
  input  data_t       reg_dst,
  input  data_t       src_buf,
  input  data_t       dst_buf,
  output data_t       op_src,
  output data_t       op_dst
);

  logic src_in_mem;
  logic dst_in_mem;

  assign src_in_mem = (cur.as == AS_IDX) || (cur.as == AS_ABS);
  assign dst_in_mem = (cur.ad != AD_REG);

  always_comb begin
    op_src = '0;
    op_dst = '0;
    case (state)
      E_SRC_RD: begin                           // Address = base + sext
        op_src = (cur.as == AS_IDX) ? reg_src : '0;
        op_dst = cur.sext;
      end
      E_DST_RD, E_DST_WR: begin                 // Address = dext + base
        op_src = cur.dext;
        op_dst = (cur.ad == AD_IDX) ? reg_dst : '0;
      end
      E_EXEC: begin
        op_src = (cur.as == AS_IMM) ? cur.sext :
                 src_in_mem         ? src_buf  : reg_src;
        op_dst = dst_in_mem ? dst_buf : reg_dst;
      end
      default: begin
        op_src = '0;                            // Idle, adder unused
        op_dst = '0;
      end
    endcase
  end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file import exec_pkg::*; (
  input  logic     mclk,
  input  logic     puc,
  input  reg_idx_t src_sel,
  input  reg_idx_t dst_sel,
  input  reg_idx_t dbg_reg_sel,
  input  logic     wr_en,
  input  data_t    wr_data,
  input  logic     bw,
  input  flags_t   flags_wr,                    // Per-bit write mask
  input  flags_t   flags_in,
  output data_t    reg_src,
  output data_t    reg_dst,
  output data_t    dbg_reg_data,
  output flags_t   flags
);

  data_t  regs [16];
  data_t  wr_val;
  flags_t flags_nxt;

  //======================================================================
  // General registers
  //======================================================================
  assign wr_val = bw ? {8'h00, wr_data[7:0]} : wr_data;  // .B clears high byte

  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[dst_sel] <= wr_val;                  // End of EXEC
    end
  end

  assign reg_src      = regs[src_sel];
  assign reg_dst      = regs[dst_sel];
  assign dbg_reg_data = regs[dbg_reg_sel];      // Debug peek, combinational

  //======================================================================
  // Status flags
  //======================================================================
  // Masked bits take the ALU value, others keep theirs
  assign flags_nxt = (flags & ~flags_wr) | (flags_in & flags_wr);

  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      flags <= '0;
    end else begin
      flags <= flags_nxt;
    end
  end

endmodule

/* rtl/exec_sequencer.sv */
`timescale 1ns/1ps

module exec_sequencer import exec_pkg::*; (
  input  logic        mclk,
  input  logic        puc,
  input  dec_inst_t   inst,
  input  logic        inst_valid,
  output logic        inst_ready,
  input  logic        ack,
  output exec_state_e state,
  output dec_inst_t   cur,
  output mem_ctl_t    mem_ctl
);

  exec_state_e state_nxt;

  function automatic logic src_mem(input dec_inst_t i);
    return (i.as == AS_IDX) || (i.as == AS_ABS);  // Source lives in memory
  endfunction

  function automatic logic dst_mem(input dec_inst_t i);
    return i.ad != AD_REG;                      // Destination lives in memory
  endfunction

  assign inst_ready = (state == E_IDLE);

  //======================================================================
  // Phase selection
  //======================================================================
  always_comb begin
    state_nxt = state;
    case (state)
      E_IDLE:   if (inst_valid) state_nxt = src_mem(inst) ? E_SRC_RD :
                                            dst_mem(inst) ? E_DST_RD : E_EXEC;
      E_SRC_RD: if (ack) state_nxt = dst_mem(cur) ? E_DST_RD : E_EXEC;
      E_DST_RD: if (ack) state_nxt = E_EXEC;
      E_EXEC:   state_nxt = (dst_mem(cur) && (cur.op != ALU_CMP)) ? E_DST_WR : E_IDLE;
      E_DST_WR: if (ack) state_nxt = E_IDLE;
      default:  state_nxt = E_IDLE;             // Recover from illegal codes
    endcase
  end

  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      state <= E_IDLE;
      cur   <= '0;
    end else begin
      state <= state_nxt;
      if (inst_valid && inst_ready) cur <= inst;  // Capture at handshake
    end
  end

  assign mem_ctl.req   = (state == E_SRC_RD) || (state == E_DST_RD) || (state == E_DST_WR);
  assign mem_ctl.we    = (state == E_DST_WR);
  assign mem_ctl.phase = (state != E_SRC_RD);   // Steers read buffer load

  // Wait states hold the phase
  a_hold_until_ack: assert property (@(posedge mclk) disable iff (puc)
    (mem_ctl.req && !ack) |=> (state == $past(state)));

  // An accepted instruction always leaves IDLE
  a_ready_drops: assert property (@(posedge mclk) disable iff (puc)
    (inst_valid && inst_ready) |=> !inst_ready);

endmodule

/* rtl/exec_pkg.sv */
package exec_pkg;

  //======================================================================
  // Basic words
  //======================================================================
  typedef logic [15:0] data_t;                  // Data or address word
  typedef logic [3:0]  reg_idx_t;               // One of sixteen registers

  typedef enum logic [2:0] {
    ALU_MOV = 3'd0,                             // dst = src
    ALU_ADD = 3'd1,                             // dst = dst + src
    ALU_SUB = 3'd2,                             // dst = dst - src
    ALU_CMP = 3'd3,                             // Flags of dst - src only
    ALU_AND = 3'd4,                             // dst = dst & src
    ALU_BIS = 3'd5,                             // dst = dst | src
    ALU_XOR = 3'd6                              // dst = dst ^ src
  } alu_op_e;

  typedef enum logic [1:0] {
    AS_REG = 2'd0,                              // Rn
    AS_IDX = 2'd1,                              // x(Rn)
    AS_ABS = 2'd2,                              // &x
    AS_IMM = 2'd3                               // #x
  } src_mode_e;

  typedef enum logic [1:0] {
    AD_REG = 2'd0,                              // Rn
    AD_IDX = 2'd1,                              // x(Rn)
    AD_ABS = 2'd2                               // &x
  } dst_mode_e;

  typedef enum logic [2:0] {
    E_IDLE   = 3'd0,                            // Waiting for an instruction
    E_SRC_RD = 3'd1,                            // Source operand fetch
    E_DST_RD = 3'd2,                            // Destination operand fetch
    E_EXEC   = 3'd3,                            // ALU cycle
    E_DST_WR = 3'd4                             // Result write back to memory
  } exec_state_e;

  typedef struct packed {
    logic v;                                    // Signed overflow
    logic n;                                    // Negative
    logic z;                                    // Zero
    logic c;                                    // Carry
  } flags_t;

  typedef struct packed {
    alu_op_e   op;
    logic      bw;                              // Byte width
    src_mode_e as;
    dst_mode_e ad;
    reg_idx_t  src;
    reg_idx_t  dst;
    data_t     sext;                            // Source extension word
    data_t     dext;                            // Destination extension word
  } dec_inst_t;

  // One memory word, seen whole or by byte lane
  typedef union packed {
    data_t word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } b;
  } mem_word_u;

  //======================================================================
  // Bus bundles
  //======================================================================
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] sel;                            // {hi lane, lo lane}
    data_t      adr;
    data_t      dat;
  } wb_req_t;

  typedef struct packed {
    data_t dat;
    logic  ack;
  } wb_rsp_t;

  typedef struct packed {
    logic req;                                  // Memory phase active
    logic we;                                   // Write phase
    logic phase;                                // 0 source, 1 destination
  } mem_ctl_t;

endpackage
